// ==== source/alu_pkg.sv ====
package alu_pkg;

    localparam int data_width = 32;
    localparam int imm_width = 16;

    localparam int reg_count = 16;
    localparam int reg_idx_width = 4;
    localparam int flag_count = 4;
    localparam int flag_idx_width = 2;

    localparam int queue_depth = 4;  // also the starting credit count of each sender
    localparam int queue_ptr_width = 2;
    localparam int credit_width = 3;  // holds 0 to queue_depth
    localparam int port_count = 2;

    localparam int op_width = 4;

    typedef enum logic [op_width-1:0] {
        op_add, op_sub, op_shl, op_shr, op_mov, op_load_low, op_load_high,
        op_cmp_eq, op_cmp_lt, op_cmp_gt, op_flag_not, op_flag_and, op_flag_mov,
        op_jump, op_branch
    } alu_op_e;

    // command packing, msb first: opcode, dst, src_a, src_b, imm, flag_a, flag_b
    // flag operations write the flag named by the low bits of dst
    localparam int cmd_width = 36;
    localparam int cmd_flag_b_lsb = 0;
    localparam int cmd_flag_a_lsb = 2;
    localparam int cmd_imm_lsb = 4;
    localparam int cmd_src_b_lsb = 20;
    localparam int cmd_src_a_lsb = 24;
    localparam int cmd_dst_lsb = 28;
    localparam int cmd_op_lsb = 32;

    // result_kind codes
    localparam logic [1:0] kind_reg = 2'd0;
    localparam logic [1:0] kind_flag = 2'd1;
    localparam logic [1:0] kind_addr = 2'd2;
    localparam logic [1:0] kind_none = 2'd3;  // unused opcode, nothing written

endpackage

// ==== source/cmd_queue.sv ====
`timescale 1ns/1ps

module cmd_queue (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          push,
    input  logic [alu_pkg::cmd_width-1:0] push_cmd,
    input  logic                          pop,
    output logic                          not_empty,
    output logic [alu_pkg::cmd_width-1:0] head,
    output logic                          credit_return
);

    logic [alu_pkg::cmd_width-1:0]       mem [alu_pkg::queue_depth];
    logic [alu_pkg::queue_ptr_width-1:0] wr_ptr;
    logic [alu_pkg::queue_ptr_width-1:0] rd_ptr;
    logic [alu_pkg::credit_width-1:0]    count;

    assign not_empty = (count != '0);
    assign head = mem[rd_ptr];

    always_ff @(posedge clock)
    begin
        if (push)
            mem[wr_ptr] <= push_cmd;
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two so the pointer wraps
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + alu_pkg::credit_width'(push) - alu_pkg::credit_width'(pop);
            credit_return <= pop;  // the freed slot goes back to the sender
        end
    end

endmodule

// ==== source/issue_arbiter.sv ====
`timescale 1ns/1ps

module issue_arbiter (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          not_empty_0,
    input  logic                          not_empty_1,
    input  logic [alu_pkg::cmd_width-1:0] head_0,
    input  logic [alu_pkg::cmd_width-1:0] head_1,
    output logic                          pop_0,
    output logic                          pop_1,
    output logic                          issue_valid,
    output logic                          issue_port,
    output logic [alu_pkg::cmd_width-1:0] issue_cmd
);

    logic                             last_grant;
    logic                             sel;
    logic [alu_pkg::port_count-1:0]   grant;

    // with both queues waiting the port that was not served last time wins
    assign sel = (not_empty_0 && not_empty_1) ? ~last_grant : not_empty_1;
    assign issue_valid = not_empty_0 | not_empty_1;
    assign grant = issue_valid ? (sel ? 2'b10 : 2'b01) : 2'b00;

    assign pop_0 = grant[0];
    assign pop_1 = grant[1];
    assign issue_port = sel;
    assign issue_cmd = sel ? head_1 : head_0;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            last_grant <= 1'b1;  // port 0 goes first
        else if (issue_valid)
            last_grant <= sel;
    end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic [alu_pkg::reg_idx_width-1:0]  rd_a_idx,
    input  logic [alu_pkg::reg_idx_width-1:0]  rd_b_idx,
    output logic [alu_pkg::data_width-1:0]     rd_a_data,
    output logic [alu_pkg::data_width-1:0]     rd_b_data,
    input  logic [alu_pkg::flag_idx_width-1:0] flag_a_idx,
    input  logic [alu_pkg::flag_idx_width-1:0] flag_b_idx,
    output logic                               flag_a_val,
    output logic                               flag_b_val,
    input  logic                               reg_we,
    input  logic [alu_pkg::reg_idx_width-1:0]  reg_wr_idx,
    input  logic [alu_pkg::data_width-1:0]     reg_wr_data,
    input  logic                               flag_we,
    input  logic [alu_pkg::flag_idx_width-1:0] flag_wr_idx,
    input  logic                               flag_wr_val
);

    logic [alu_pkg::data_width-1:0] regs [alu_pkg::reg_count];
    logic [alu_pkg::flag_count-1:0] flags;

    // reads see the value written at the previous edge
    assign rd_a_data = regs[rd_a_idx];
    assign rd_b_data = regs[rd_b_idx];
    assign flag_a_val = flags[flag_a_idx];
    assign flag_b_val = flags[flag_b_idx];

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            regs <= '{default: '0};
            flags <= '0;
        end
        else
        begin
            if (reg_we)
                regs[reg_wr_idx] <= reg_wr_data;
            if (flag_we)
                flags[flag_wr_idx] <= flag_wr_val;
        end
    end

endmodule

// ==== source/alu_exec.sv ====
`timescale 1ns/1ps

module alu_exec (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               issue_valid,
    input  logic                               issue_port,
    input  logic [alu_pkg::cmd_width-1:0]      issue_cmd,
    output logic [alu_pkg::reg_idx_width-1:0]  rd_a_idx,
    output logic [alu_pkg::reg_idx_width-1:0]  rd_b_idx,
    input  logic [alu_pkg::data_width-1:0]     rd_a_data,
    input  logic [alu_pkg::data_width-1:0]     rd_b_data,
    output logic [alu_pkg::flag_idx_width-1:0] flag_a_idx,
    output logic [alu_pkg::flag_idx_width-1:0] flag_b_idx,
    input  logic                               flag_a_val,
    input  logic                               flag_b_val,
    output logic                               reg_we,
    output logic [alu_pkg::reg_idx_width-1:0]  reg_wr_idx,
    output logic [alu_pkg::data_width-1:0]     reg_wr_data,
    output logic                               flag_we,
    output logic [alu_pkg::flag_idx_width-1:0] flag_wr_idx,
    output logic                               flag_wr_val,
    output logic                               result_valid,
    output logic                               result_port,
    output logic [1:0]                         result_kind,
    output logic [alu_pkg::data_width-1:0]     result_value,
    output logic                               result_flag,
    output logic                               addr_change,
    output logic [alu_pkg::data_width-1:0]     next_addr
);

    logic                                iss_valid;
    logic                                iss_port;
    logic [alu_pkg::cmd_width-1:0]       iss_cmd;
    alu_pkg::alu_op_e                    op;
    logic [alu_pkg::reg_idx_width-1:0]   dst;
    logic [alu_pkg::imm_width-1:0]       imm;
    logic [alu_pkg::data_width-1:0]      opa;
    logic [alu_pkg::data_width-1:0]      opb;
    logic [alu_pkg::data_width-1:0]      value;
    logic                                flag;
    logic [1:0]                          kind;
    logic                                addr_ch;
    logic [alu_pkg::data_width-1:0]      addr;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            iss_valid <= 1'b0;
        else
            iss_valid <= issue_valid;
    end

    always_ff @(posedge clock)
    begin
        iss_port <= issue_port;
        iss_cmd <= issue_cmd;
    end

    assign op = alu_pkg::alu_op_e'(iss_cmd[alu_pkg::cmd_op_lsb +: alu_pkg::op_width]);
    assign dst = iss_cmd[alu_pkg::cmd_dst_lsb +: alu_pkg::reg_idx_width];
    assign imm = iss_cmd[alu_pkg::cmd_imm_lsb +: alu_pkg::imm_width];
    assign rd_a_idx = iss_cmd[alu_pkg::cmd_src_a_lsb +: alu_pkg::reg_idx_width];
    assign rd_b_idx = iss_cmd[alu_pkg::cmd_src_b_lsb +: alu_pkg::reg_idx_width];
    assign flag_a_idx = iss_cmd[alu_pkg::cmd_flag_a_lsb +: alu_pkg::flag_idx_width];
    assign flag_b_idx = iss_cmd[alu_pkg::cmd_flag_b_lsb +: alu_pkg::flag_idx_width];
    assign opa = rd_a_data;
    assign opb = rd_b_data;

    always_comb
    begin
        case (op)
            alu_pkg::op_add:       value = opa + opb;
            alu_pkg::op_sub:       value = opa - opb;
            alu_pkg::op_shl:       value = ~(~opa << opb);  // ones fill, 32 and up gives all ones
            alu_pkg::op_shr:       value = ~(~opa >> opb);
            alu_pkg::op_mov:       value = opa;
            alu_pkg::op_load_low:  value = {opa[alu_pkg::data_width-1:alu_pkg::imm_width], imm};
            alu_pkg::op_load_high: value = {imm, opa[alu_pkg::imm_width-1:0]};
            default:               value = '0;
        endcase
    end

    always_comb
    begin
        case (op)
            alu_pkg::op_cmp_eq:   flag = (opa == opb);
            alu_pkg::op_cmp_lt:   flag = (opa < opb);
            alu_pkg::op_cmp_gt:   flag = (opa > opb);
            alu_pkg::op_flag_not: flag = ~flag_a_val;
            alu_pkg::op_flag_and: flag = flag_a_val & flag_b_val;
            alu_pkg::op_flag_mov: flag = flag_a_val;
            default:              flag = 1'b0;
        endcase
    end

    always_comb
    begin
        case (op)
            alu_pkg::op_add, alu_pkg::op_sub, alu_pkg::op_shl, alu_pkg::op_shr,
            alu_pkg::op_mov, alu_pkg::op_load_low, alu_pkg::op_load_high:
                kind = alu_pkg::kind_reg;
            alu_pkg::op_cmp_eq, alu_pkg::op_cmp_lt, alu_pkg::op_cmp_gt,
            alu_pkg::op_flag_not, alu_pkg::op_flag_and, alu_pkg::op_flag_mov:
                kind = alu_pkg::kind_flag;
            alu_pkg::op_jump, alu_pkg::op_branch:
                kind = alu_pkg::kind_addr;
            default:
                kind = alu_pkg::kind_none;
        endcase
    end

    // a branch that is not taken still reports, with addr_change low
    assign addr_ch = (op == alu_pkg::op_jump) || (op == alu_pkg::op_branch && flag_a_val);
    assign addr = addr_ch ? opa : '0;

    // writes land at the same edge as the result register
    assign reg_we = iss_valid && (kind == alu_pkg::kind_reg);
    assign reg_wr_idx = dst;
    assign reg_wr_data = value;
    assign flag_we = iss_valid && (kind == alu_pkg::kind_flag);
    assign flag_wr_idx = dst[alu_pkg::flag_idx_width-1:0];
    assign flag_wr_val = flag;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            result_valid <= 1'b0;
            addr_change <= 1'b0;
        end
        else
        begin
            result_valid <= iss_valid;
            addr_change <= iss_valid && addr_ch;
        end
    end

    always_ff @(posedge clock)
    begin
        result_port <= iss_port;
        result_kind <= kind;
        result_value <= value;
        result_flag <= flag;
        next_addr <= addr;
    end

endmodule

// ==== source/alu_cluster.sv ====
`timescale 1ns/1ps

module alu_cluster (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               cmd_valid_0,
    input  alu_pkg::alu_op_e                   cmd_op_0,
    input  logic [alu_pkg::reg_idx_width-1:0]  cmd_dst_0,
    input  logic [alu_pkg::reg_idx_width-1:0]  cmd_src_a_0,
    input  logic [alu_pkg::reg_idx_width-1:0]  cmd_src_b_0,
    input  logic [alu_pkg::imm_width-1:0]      cmd_imm_0,
    input  logic [alu_pkg::flag_idx_width-1:0] cmd_flag_a_0,
    input  logic [alu_pkg::flag_idx_width-1:0] cmd_flag_b_0,
    output logic                               credit_return_0,
    input  logic                               cmd_valid_1,
    input  alu_pkg::alu_op_e                   cmd_op_1,
    input  logic [alu_pkg::reg_idx_width-1:0]  cmd_dst_1,
    input  logic [alu_pkg::reg_idx_width-1:0]  cmd_src_a_1,
    input  logic [alu_pkg::reg_idx_width-1:0]  cmd_src_b_1,
    input  logic [alu_pkg::imm_width-1:0]      cmd_imm_1,
    input  logic [alu_pkg::flag_idx_width-1:0] cmd_flag_a_1,
    input  logic [alu_pkg::flag_idx_width-1:0] cmd_flag_b_1,
    output logic                               credit_return_1,
    output logic                               result_valid,
    output logic                               result_port,
    output logic [1:0]                         result_kind,
    output logic [alu_pkg::data_width-1:0]     result_value,
    output logic                               result_flag,
    output logic                               addr_change,
    output logic [alu_pkg::data_width-1:0]     next_addr
);

    logic                               not_empty_0;
    logic                               not_empty_1;
    logic [alu_pkg::cmd_width-1:0]      head_0;
    logic [alu_pkg::cmd_width-1:0]      head_1;
    logic                               pop_0;
    logic                               pop_1;
    logic                               issue_valid;
    logic                               issue_port;
    logic [alu_pkg::cmd_width-1:0]      issue_cmd;
    logic [alu_pkg::reg_idx_width-1:0]  rd_a_idx;
    logic [alu_pkg::reg_idx_width-1:0]  rd_b_idx;
    logic [alu_pkg::data_width-1:0]     rd_a_data;
    logic [alu_pkg::data_width-1:0]     rd_b_data;
    logic [alu_pkg::flag_idx_width-1:0] flag_a_idx;
    logic [alu_pkg::flag_idx_width-1:0] flag_b_idx;
    logic                               flag_a_val;
    logic                               flag_b_val;
    logic                               reg_we;
    logic [alu_pkg::reg_idx_width-1:0]  reg_wr_idx;
    logic [alu_pkg::data_width-1:0]     reg_wr_data;
    logic                               flag_we;
    logic [alu_pkg::flag_idx_width-1:0] flag_wr_idx;
    logic                               flag_wr_val;

    // fields are packed in the order given in alu_pkg
    cmd_queue u_queue_0 (
        .clock(clock), .rst_n(rst_n), .push(cmd_valid_0),
        .push_cmd({cmd_op_0, cmd_dst_0, cmd_src_a_0, cmd_src_b_0, cmd_imm_0,
                   cmd_flag_a_0, cmd_flag_b_0}),
        .pop(pop_0), .not_empty(not_empty_0), .head(head_0),
        .credit_return(credit_return_0)
    );

    cmd_queue u_queue_1 (
        .clock(clock), .rst_n(rst_n), .push(cmd_valid_1),
        .push_cmd({cmd_op_1, cmd_dst_1, cmd_src_a_1, cmd_src_b_1, cmd_imm_1,
                   cmd_flag_a_1, cmd_flag_b_1}),
        .pop(pop_1), .not_empty(not_empty_1), .head(head_1),
        .credit_return(credit_return_1)
    );

    issue_arbiter u_arbiter (
        .clock(clock), .rst_n(rst_n),
        .not_empty_0(not_empty_0), .not_empty_1(not_empty_1),
        .head_0(head_0), .head_1(head_1), .pop_0(pop_0), .pop_1(pop_1),
        .issue_valid(issue_valid), .issue_port(issue_port), .issue_cmd(issue_cmd)
    );

    alu_exec u_exec (
        .clock(clock), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_port(issue_port), .issue_cmd(issue_cmd),
        .rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx),
        .rd_a_data(rd_a_data), .rd_b_data(rd_b_data),
        .flag_a_idx(flag_a_idx), .flag_b_idx(flag_b_idx),
        .flag_a_val(flag_a_val), .flag_b_val(flag_b_val),
        .reg_we(reg_we), .reg_wr_idx(reg_wr_idx), .reg_wr_data(reg_wr_data),
        .flag_we(flag_we), .flag_wr_idx(flag_wr_idx), .flag_wr_val(flag_wr_val),
        .result_valid(result_valid), .result_port(result_port),
        .result_kind(result_kind), .result_value(result_value),
        .result_flag(result_flag), .addr_change(addr_change), .next_addr(next_addr)
    );

    register_file u_regfile (
        .clock(clock), .rst_n(rst_n),
        .rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx),
        .rd_a_data(rd_a_data), .rd_b_data(rd_b_data),
        .flag_a_idx(flag_a_idx), .flag_b_idx(flag_b_idx),
        .flag_a_val(flag_a_val), .flag_b_val(flag_b_val),
        .reg_we(reg_we), .reg_wr_idx(reg_wr_idx), .reg_wr_data(reg_wr_data),
        .flag_we(flag_we), .flag_wr_idx(flag_wr_idx), .flag_wr_val(flag_wr_val)
    );

endmodule

// ==== dv/alu_cluster_checker.sv ====
`timescale 1ns/1ps

module alu_cluster_checker (
    input logic clock,
    input logic rst_n,
    input logic cmd_valid_0,
    input logic cmd_valid_1,
    input logic pop_0,
    input logic pop_1,
    input logic credit_return_0,
    input logic credit_return_1,
    input logic result_valid,
    input logic addr_change
);

    logic [alu_pkg::credit_width-1:0] fill_0;
    logic [alu_pkg::credit_width-1:0] fill_1;
    int                               failures = 0;

    // shadow occupancy of each command queue
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            fill_0 <= '0;
            fill_1 <= '0;
        end
        else
        begin
            fill_0 <= fill_0 + alu_pkg::credit_width'(cmd_valid_0) - alu_pkg::credit_width'(pop_0);
            fill_1 <= fill_1 + alu_pkg::credit_width'(cmd_valid_1) - alu_pkg::credit_width'(pop_1);
        end
    end

    single_pop: assert property (@(posedge clock) disable iff (!rst_n) !(pop_0 && pop_1))
    else
    begin
        failures++;
        $error("both queues popped in one cycle");
    end

    no_overflow_0: assert property (@(posedge clock) disable iff (!rst_n)
        cmd_valid_0 |-> fill_0 != alu_pkg::queue_depth)
    else
    begin
        failures++;
        $error("push into the full queue of port 0");
    end

    no_overflow_1: assert property (@(posedge clock) disable iff (!rst_n)
        cmd_valid_1 |-> fill_1 != alu_pkg::queue_depth)
    else
    begin
        failures++;
        $error("push into the full queue of port 1");
    end

    quiet_after_reset: assert property (@(posedge clock) !rst_n |=> !result_valid && !addr_change)
    else
    begin
        failures++;
        $error("result outputs active right after reset");
    end

    credit_after_pop_0: assert property (@(posedge clock) disable iff (!rst_n)
        pop_0 |=> credit_return_0)
    else
    begin
        failures++;
        $error("pop on port 0 without a credit pulse");
    end

    credit_after_pop_1: assert property (@(posedge clock) disable iff (!rst_n)
        pop_1 |=> credit_return_1)
    else
    begin
        failures++;
        $error("pop on port 1 without a credit pulse");
    end

endmodule

bind alu_cluster alu_cluster_checker u_checker (
    .clock(clock),
    .rst_n(rst_n),
    .cmd_valid_0(cmd_valid_0),
    .cmd_valid_1(cmd_valid_1),
    .pop_0(pop_0),
    .pop_1(pop_1),
    .credit_return_0(credit_return_0),
    .credit_return_1(credit_return_1),
    .result_valid(result_valid),
    .addr_change(addr_change)
);

// ==== dv/alu_cluster_tb.sv ====
`timescale 1ns/1ps

module alu_cluster_tb;

    localparam int max_rows = 32;

    logic                               clock;
    logic                               rst_n;
    logic                               cmd_valid [2];
    alu_pkg::alu_op_e                   cmd_op [2];
    logic [alu_pkg::reg_idx_width-1:0]  cmd_dst [2];
    logic [alu_pkg::reg_idx_width-1:0]  cmd_src_a [2];
    logic [alu_pkg::reg_idx_width-1:0]  cmd_src_b [2];
    logic [alu_pkg::imm_width-1:0]      cmd_imm [2];
    logic [alu_pkg::flag_idx_width-1:0] cmd_flag_a [2];
    logic [alu_pkg::flag_idx_width-1:0] cmd_flag_b [2];
    logic                               credit_return [2];
    logic                               result_valid;
    logic                               result_port;
    logic [1:0]                         result_kind;
    logic [alu_pkg::data_width-1:0]     result_value;
    logic                               result_flag;
    logic                               addr_change;
    logic [alu_pkg::data_width-1:0]     next_addr;

    // stimulus and expected values, one entry per row
    string                              row_name [max_rows];
    alu_pkg::alu_op_e                   row_op [max_rows];
    logic [alu_pkg::reg_idx_width-1:0]  row_dst [max_rows];
    logic [alu_pkg::reg_idx_width-1:0]  row_src_a [max_rows];
    logic [alu_pkg::reg_idx_width-1:0]  row_src_b [max_rows];
    logic [alu_pkg::imm_width-1:0]      row_imm [max_rows];
    logic [alu_pkg::flag_idx_width-1:0] row_flag_a [max_rows];
    logic [alu_pkg::flag_idx_width-1:0] row_flag_b [max_rows];
    logic [1:0]                         row_kind [max_rows];
    logic [alu_pkg::data_width-1:0]     row_value [max_rows];
    logic                               row_addr_change [max_rows];
    int                                 row_count;
    int                                 port_rows [2][max_rows];  // row numbers in send order
    int                                 port_len [2];
    int                                 next_row [2];
    int                                 checked [2];
    int                                 credits [2];
    int                                 sent_total;
    int                                 result_total;
    int                                 errors;
    int                                 cycles;
    logic [15:0]                        lfsr;

    alu_cluster UUT (
        .clock(clock), .rst_n(rst_n),
        .cmd_valid_0(cmd_valid[0]), .cmd_op_0(cmd_op[0]), .cmd_dst_0(cmd_dst[0]),
        .cmd_src_a_0(cmd_src_a[0]), .cmd_src_b_0(cmd_src_b[0]), .cmd_imm_0(cmd_imm[0]),
        .cmd_flag_a_0(cmd_flag_a[0]), .cmd_flag_b_0(cmd_flag_b[0]),
        .credit_return_0(credit_return[0]),
        .cmd_valid_1(cmd_valid[1]), .cmd_op_1(cmd_op[1]), .cmd_dst_1(cmd_dst[1]),
        .cmd_src_a_1(cmd_src_a[1]), .cmd_src_b_1(cmd_src_b[1]), .cmd_imm_1(cmd_imm[1]),
        .cmd_flag_a_1(cmd_flag_a[1]), .cmd_flag_b_1(cmd_flag_b[1]),
        .credit_return_1(credit_return[1]),
        .result_valid(result_valid), .result_port(result_port), .result_kind(result_kind),
        .result_value(result_value), .result_flag(result_flag),
        .addr_change(addr_change), .next_addr(next_addr)
    );

    always #4 clock = ~clock;

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic add_row(input string name, input int port, input alu_pkg::alu_op_e op,
                           input int dst, input int src_a, input int src_b, input int imm,
                           input int flag_a, input int flag_b, input logic [1:0] kind,
                           input logic [31:0] value, input logic addr_change_exp);
        row_name[row_count] = name;
        row_op[row_count] = op;
        row_dst[row_count] = alu_pkg::reg_idx_width'(dst);
        row_src_a[row_count] = alu_pkg::reg_idx_width'(src_a);
        row_src_b[row_count] = alu_pkg::reg_idx_width'(src_b);
        row_imm[row_count] = alu_pkg::imm_width'(imm);
        row_flag_a[row_count] = alu_pkg::flag_idx_width'(flag_a);
        row_flag_b[row_count] = alu_pkg::flag_idx_width'(flag_b);
        row_kind[row_count] = kind;
        row_value[row_count] = value;
        row_addr_change[row_count] = addr_change_exp;
        port_rows[port][port_len[port]] = row_count;
        port_len[port]++;
        row_count++;
    endtask

    // port 0 owns r0 to r7 and f0, f1 while port 1 owns r8 to r15 and f2, f3
    task automatic load_table();
        add_row("p0_mov_from_r5", 0, alu_pkg::op_mov, 0, 5, 0, 0, 0, 0,
                alu_pkg::kind_reg, 32'h0000_0000, 1'b0);
        add_row("p0_load_low_r1", 0, alu_pkg::op_load_low, 1, 1, 0, 'h5678, 0, 0,
                alu_pkg::kind_reg, 32'h0000_5678, 1'b0);
        add_row("p0_load_high_r1", 0, alu_pkg::op_load_high, 1, 1, 0, 'h1234, 0, 0,
                alu_pkg::kind_reg, 32'h1234_5678, 1'b0);
        add_row("p0_load_high_r2", 0, alu_pkg::op_load_high, 2, 2, 0, 'hffff, 0, 0,
                alu_pkg::kind_reg, 32'hffff_0000, 1'b0);
        add_row("p0_add_wrap", 0, alu_pkg::op_add, 3, 1, 2, 0, 0, 0,
                alu_pkg::kind_reg, 32'h1233_5678, 1'b0);
        add_row("p0_sub_wrap", 0, alu_pkg::op_sub, 4, 1, 2, 0, 0, 0,
                alu_pkg::kind_reg, 32'h1235_5678, 1'b0);
        add_row("p0_cmp_lt", 0, alu_pkg::op_cmp_lt, 0, 1, 2, 0, 0, 0,
                alu_pkg::kind_flag, 32'h1, 1'b0);
        add_row("p0_cmp_eq", 0, alu_pkg::op_cmp_eq, 1, 3, 4, 0, 0, 0,
                alu_pkg::kind_flag, 32'h0, 1'b0);
        add_row("p0_flag_not", 0, alu_pkg::op_flag_not, 1, 0, 0, 0, 1, 0,
                alu_pkg::kind_flag, 32'h1, 1'b0);
        add_row("p0_flag_and", 0, alu_pkg::op_flag_and, 0, 0, 0, 0, 0, 1,
                alu_pkg::kind_flag, 32'h1, 1'b0);
        add_row("p0_jump", 0, alu_pkg::op_jump, 0, 1, 0, 0, 0, 0,
                alu_pkg::kind_addr, 32'h1234_5678, 1'b1);
        add_row("p0_branch_taken", 0, alu_pkg::op_branch, 0, 4, 0, 0, 0, 0,
                alu_pkg::kind_addr, 32'h1235_5678, 1'b1);
        add_row("p1_load_low_r9", 1, alu_pkg::op_load_low, 9, 9, 0, 'h00f0, 0, 0,
                alu_pkg::kind_reg, 32'h0000_00f0, 1'b0);
        add_row("p1_load_low_r11", 1, alu_pkg::op_load_low, 11, 11, 0, 'h001f, 0, 0,
                alu_pkg::kind_reg, 32'h0000_001f, 1'b0);
        add_row("p1_load_low_r12", 1, alu_pkg::op_load_low, 12, 12, 0, 'h0028, 0, 0,
                alu_pkg::kind_reg, 32'h0000_0028, 1'b0);
        add_row("p1_shl_0", 1, alu_pkg::op_shl, 13, 9, 10, 0, 0, 0,
                alu_pkg::kind_reg, 32'h0000_00f0, 1'b0);
        add_row("p1_shl_31", 1, alu_pkg::op_shl, 13, 9, 11, 0, 0, 0,
                alu_pkg::kind_reg, 32'h7fff_ffff, 1'b0);
        add_row("p1_shr_31", 1, alu_pkg::op_shr, 14, 9, 11, 0, 0, 0,
                alu_pkg::kind_reg, 32'hffff_fffe, 1'b0);
        add_row("p1_shl_40", 1, alu_pkg::op_shl, 15, 9, 12, 0, 0, 0,
                alu_pkg::kind_reg, 32'hffff_ffff, 1'b0);
        add_row("p1_shr_40", 1, alu_pkg::op_shr, 13, 9, 12, 0, 0, 0,
                alu_pkg::kind_reg, 32'hffff_ffff, 1'b0);
        add_row("p1_cmp_gt", 1, alu_pkg::op_cmp_gt, 2, 12, 11, 0, 0, 0,
                alu_pkg::kind_flag, 32'h1, 1'b0);
        add_row("p1_flag_not", 1, alu_pkg::op_flag_not, 3, 0, 0, 0, 2, 0,
                alu_pkg::kind_flag, 32'h0, 1'b0);
        add_row("p1_flag_mov", 1, alu_pkg::op_flag_mov, 2, 0, 0, 0, 3, 0,
                alu_pkg::kind_flag, 32'h0, 1'b0);
        add_row("p1_branch_not_taken", 1, alu_pkg::op_branch, 0, 9, 0, 0, 2, 0,
                alu_pkg::kind_addr, 32'h0000_0000, 1'b0);
    endtask

    // port p sends its next row or idles, never beyond its credits
    task automatic send_step(input int p);
        int row;
        cmd_valid[p] = 1'b0;
        if (credits[p] > 0 && next_row[p] < port_len[p])
        begin
            lfsr = lfsr_step(lfsr);
            if (lfsr[0])
            begin
                row = port_rows[p][next_row[p]];
                cmd_valid[p] = 1'b1;
                cmd_op[p] = row_op[row];
                cmd_dst[p] = row_dst[row];
                cmd_src_a[p] = row_src_a[row];
                cmd_src_b[p] = row_src_b[row];
                cmd_imm[p] = row_imm[row];
                cmd_flag_a[p] = row_flag_a[row];
                cmd_flag_b[p] = row_flag_b[row];
                next_row[p]++;
            end
        end
    endtask

    task automatic check_result();
        int p;
        int row;
        logic [alu_pkg::data_width-1:0] actual;
        p = int'(result_port);
        result_total++;
        assert (sent_total > 0 && checked[p] < port_len[p])
        else
        begin
            errors++;
            $display("a result came out on port %0d with no command waiting for it", p);
        end
        if (checked[p] < port_len[p])
        begin
            row = port_rows[p][checked[p]];  // results of one port keep their order
            checked[p]++;
            if (row_kind[row] == alu_pkg::kind_flag)
                actual = {31'b0, result_flag};
            else if (row_kind[row] == alu_pkg::kind_addr)
                actual = next_addr;
            else
                actual = result_value;
            assert (result_kind == row_kind[row] && actual == row_value[row]
                    && addr_change == row_addr_change[row])
            else
            begin
                errors++;
                $display("Error %s: expected kind %0d value %h addr_change %b, %s %0d %s %h %s %b",
                         row_name[row], row_kind[row], row_value[row], row_addr_change[row],
                         "actual kind", result_kind, "value", actual, "addr_change", addr_change);
            end
        end
    endtask

    // credits move on the edge where the DUT samples valid and returns a slot
    always @(posedge clock)
    begin
        if (rst_n)
        begin
            for (int p = 0; p < 2; p++)
            begin
                credits[p] = credits[p] - int'(cmd_valid[p]) + int'(credit_return[p]);
                sent_total += int'(cmd_valid[p]);
                assert (credits[p] >= 0 && credits[p] <= alu_pkg::queue_depth)
                else
                begin
                    errors++;
                    $display("port %0d holds %0d credits, outside 0 to 4", p, credits[p]);
                end
            end
            if (result_valid)
                check_result();
        end
    end

    always @(posedge clock)
    begin
        cycles++;
        if (cycles == row_count * 6 + 50)
        begin
            $display("the run stopped after %0d cycles with %0d of %0d results received",
                     cycles, result_total, row_count);
            $display("errors %0d, checker failures %0d, results %0d of %0d",
                     errors, UUT.u_checker.failures, result_total, row_count);
            $display("TB FAILED");
            $finish;
        end
    end

    initial
    begin
        clock = 1'b0;
        rst_n = 1'b0;
        for (int p = 0; p < 2; p++)
        begin
            cmd_valid[p] = 1'b0;
            cmd_op[p] = alu_pkg::op_add;
            cmd_dst[p] = '0;
            cmd_src_a[p] = '0;
            cmd_src_b[p] = '0;
            cmd_imm[p] = '0;
            cmd_flag_a[p] = '0;
            cmd_flag_b[p] = '0;
            port_len[p] = 0;
            next_row[p] = 0;
            checked[p] = 0;
            credits[p] = alu_pkg::queue_depth;
        end
        row_count = 0;
        sent_total = 0;
        result_total = 0;
        errors = 0;
        cycles = 0;
        lfsr = 16'd61;
        load_table();
        repeat (2) @(posedge clock);
        #1 rst_n = 1'b1;
        while (next_row[0] < port_len[0] || next_row[1] < port_len[1])
        begin
            @(posedge clock);
            #1;
            send_step(0);
            send_step(1);
        end
        @(posedge clock);
        #1;
        cmd_valid[0] = 1'b0;
        cmd_valid[1] = 1'b0;
        wait (result_total >= row_count);
        repeat (4) @(posedge clock);  // room for a stray extra result
        $display("errors %0d, checker failures %0d, results %0d of %0d",
                 errors, UUT.u_checker.failures, result_total, row_count);
        if (errors == 0 && UUT.u_checker.failures == 0 && result_total == row_count)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
source/alu_pkg.sv
source/cmd_queue.sv
source/issue_arbiter.sv
source/register_file.sv
source/alu_exec.sv
source/alu_cluster.sv
dv/alu_cluster_checker.sv
dv/alu_cluster_tb.sv

// ==== Bender.yml ====
package:
  name: alu_cluster

sources:
  - source/alu_pkg.sv
  - source/cmd_queue.sv
  - source/issue_arbiter.sv
  - source/register_file.sv
  - source/alu_exec.sv
  - source/alu_cluster.sv
  - target: test
    files:
      - dv/alu_cluster_checker.sv
      - dv/alu_cluster_tb.sv
